/* src/wiener_pkg.sv */
// wiener block statistics package
// shared sizes, the pixel and result structs, and the controller states
package wiener_pkg;

	// pixel and block geometry
	localparam int PIXEL_W       = 8;
	localparam int BLOCK_LOG2    = 3;
	localparam int BLOCK_SAMPLES = 8; // must equal 2**BLOCK_LOG2

	// result widths
	localparam int VAR_W = 16; // holds the 16256 worst case

	// frames hold 2**frame_blocks_log2 blocks
	localparam int MAX_FRAME_LOG2 = 4;
	localparam int BLK_CNT_W      = 5; // counts up to 2**MAX_FRAME_LOG2

	// one input pixel, as it arrives from the source
	typedef struct packed {
		logic               sof;   // first sample of a frame
		logic               valid;
		logic [PIXEL_W-1:0] data;
	} pixel_in_t;

	// statistics of one block
	typedef struct packed {
		logic [PIXEL_W-1:0] mean;     // floored
		logic [VAR_W-1:0]   variance; // about the floored mean
	} block_stat_t;

	// controller FSM states
	typedef enum logic [1:0] {
		IDLE   = 2'd0, // between frames
		STREAM = 2'd1, // frame samples arriving
		FLUSH  = 2'd2  // last block shifted out of the delay line
	} ctrl_state_t;

endpackage

/* src/block_stats_ctrl.sv */
`timescale 1ns/1ps
// block statistics controller
// follows frame and block boundaries, drives the delay-line shift,
// marks the first replayed sample of each block and runs the end-of-frame flush
module block_stats_ctrl import wiener_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  pixel_in_t  pixel,
	input  logic       mean_valid,
	input  logic [2:0] frame_blocks_log2,
	output logic       shift_en,
	output logic       replay_start,
	output logic       last_block
);

	ctrl_state_t           state;
	ctrl_state_t           state_nxt;
	logic [BLOCK_LOG2-1:0] shift_cnt; // position inside the current block
	logic [BLK_CNT_W-1:0]  blk_cnt;   // finished blocks of this frame
	logic [BLK_CNT_W-1:0]  blk_last;
	logic                  frame_start;
	logic                  block_end;
	logic                  flush_end;

	assign frame_start = (state == IDLE) && pixel.valid && pixel.sof;
	assign block_end   = pixel.valid && (shift_cnt == BLOCK_LOG2'(BLOCK_SAMPLES - 1));
	assign flush_end   = (state == FLUSH) && (shift_cnt == BLOCK_LOG2'(BLOCK_SAMPLES - 1));
	assign blk_last    = (BLK_CNT_W'(1) << frame_blocks_log2) - BLK_CNT_W'(1);

	always_comb begin
		case (state)
			IDLE:    shift_en = frame_start;
			STREAM:  shift_en = pixel.valid;
			FLUSH:   shift_en = 1'b1; // one shift per cycle
			default: shift_en = 1'b0;
		endcase
	end

	// the sof sample is taken in IDLE, so shift_cnt 0 in STREAM is a later block
	assign replay_start = shift_en && (state != IDLE) && (shift_cnt == '0);

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (frame_start)
					state_nxt = STREAM;
			end
			STREAM: begin
				// mean pulses of all earlier blocks are in by now
				if (block_end && (blk_cnt == blk_last))
					state_nxt = FLUSH;
			end
			FLUSH: begin
				if (flush_end)
					state_nxt = IDLE;
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= IDLE;
			shift_cnt  <= '0;
			blk_cnt    <= '0;
			last_block <= 1'b0;
		end else begin
			state <= state_nxt;
			if (shift_en)
				shift_cnt <= frame_start ? BLOCK_LOG2'(1) : shift_cnt + 1'b1;
			if (frame_start)
				blk_cnt <= '0;
			else if (mean_valid)
				blk_cnt <= blk_cnt + 1'b1;
			last_block <= flush_end; // lines up with the final var_valid
		end
	end

	// source must hold off until the frame is out
	a_no_valid_in_flush: assert property (@(posedge clk) disable iff (!rst_n)
		(state == FLUSH) |-> !pixel.valid)
		else $error("pixel valid during flush");

	a_no_sof_in_stream: assert property (@(posedge clk) disable iff (!rst_n)
		(state == STREAM) |-> !(pixel.valid && pixel.sof))
		else $error("sof inside a running frame");

endmodule

/* src/mean_unit.sv */
`timescale 1ns/1ps
// block mean unit
// sums BLOCK_SAMPLES valid pixels and gives the floored mean one cycle
// after the last sample of the block
module mean_unit import wiener_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  pixel_in_t          pixel,
	output logic [PIXEL_W-1:0] mean,
	output logic               mean_valid
);

	logic [BLOCK_LOG2-1:0]         cnt;
	logic [PIXEL_W+BLOCK_LOG2-1:0] acc;
	logic [BLOCK_LOG2-1:0]         idx;
	logic [PIXEL_W+BLOCK_LOG2-1:0] sum;
	logic                          block_done;

	// sof starts a fresh block with the current sample
	assign idx = pixel.sof ? '0 : cnt;
	assign sum = (pixel.sof ? '0 : acc) + {{BLOCK_LOG2{1'b0}}, pixel.data};

	assign block_done = pixel.valid && (idx == BLOCK_LOG2'(BLOCK_SAMPLES - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt        <= '0;
			acc        <= '0;
			mean_valid <= 1'b0;
		end else begin
			mean_valid <= block_done;
			if (pixel.valid) begin
				cnt <= idx + 1'b1; // wraps at the block end
				acc <= block_done ? '0 : sum;
			end
		end
	end

	// divide by BLOCK_SAMPLES, holds until the next block
	always_ff @(posedge clk) begin
		if (block_done)
			mean <= sum[PIXEL_W+BLOCK_LOG2-1:BLOCK_LOG2];
	end

endmodule

/* src/sample_delay_line.sv */
`timescale 1ns/1ps
// sample delay line
// BLOCK_SAMPLES-deep shift register, replays each block's samples
// while the next block comes in
module sample_delay_line import wiener_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               shift_en,
	input  logic [PIXEL_W-1:0] din,
	output logic [PIXEL_W-1:0] dout
);

	logic [BLOCK_SAMPLES-1:0][PIXEL_W-1:0] taps; // taps[0] newest

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			taps <= '0;
		end else if (shift_en) begin
			taps <= {taps[BLOCK_SAMPLES-2:0], din};
		end
	end

	// sample that entered BLOCK_SAMPLES shifts ago, leaves on the next shift
	assign dout = taps[BLOCK_SAMPLES-1];

endmodule

/* src/variance_unit.sv */
`timescale 1ns/1ps
// block variance unit
// latches the block mean at the start of a replay, sums the squared
// deviations of the replayed samples and gives the floored variance
module variance_unit import wiener_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               shift_en,
	input  logic               replay_start,
	input  logic [PIXEL_W-1:0] sample,
	input  logic [PIXEL_W-1:0] mean,
	output logic [VAR_W-1:0]   variance,
	output logic               var_valid
);

	logic [PIXEL_W-1:0]          mean_q;
	logic [PIXEL_W-1:0]          mean_use;
	logic                        busy;
	logic [BLOCK_LOG2-1:0]       cnt;
	logic [BLOCK_LOG2-1:0]       idx;
	logic [VAR_W+BLOCK_LOG2-1:0] acc;
	logic [VAR_W+BLOCK_LOG2-1:0] sum;
	logic signed [PIXEL_W:0]     dev;
	logic signed [2*PIXEL_W+1:0] dev_sq;
	logic [2*PIXEL_W-1:0]        sq;
	logic                        take;
	logic                        last_take;

	// first replayed sample sees the mean before it is latched
	assign mean_use = replay_start ? mean : mean_q;

	assign dev    = $signed({1'b0, sample}) - $signed({1'b0, mean_use});
	assign dev_sq = dev * dev;
	assign sq     = dev_sq[2*PIXEL_W-1:0]; // 255*255 still fits

	assign take      = shift_en && (busy || replay_start);
	assign idx       = replay_start ? '0 : cnt;
	assign last_take = take && (idx == BLOCK_LOG2'(BLOCK_SAMPLES - 1));
	assign sum       = (replay_start ? '0 : acc)
		+ {{(VAR_W+BLOCK_LOG2-2*PIXEL_W){1'b0}}, sq};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			cnt       <= '0;
			acc       <= '0;
			var_valid <= 1'b0;
		end else begin
			var_valid <= last_take;
			if (take) begin
				cnt  <= idx + 1'b1;
				acc  <= sum;
				busy <= !last_take;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (replay_start)
			mean_q <= mean; // previous block's mean
		if (last_take)
			variance <= sum[VAR_W+BLOCK_LOG2-1:BLOCK_LOG2];
	end

	// controller must not start a replay over a running one
	a_replay_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		replay_start |-> !busy)
		else $error("replay_start while a block replay is running");

endmodule

/* src/noise_estimator.sv */
`timescale 1ns/1ps
// frame noise estimator
// sums the block variances of a frame and divides by the block count
// once the last block's variance is in
module noise_estimator import wiener_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             var_valid,
	input  logic             last_block,
	input  logic [VAR_W-1:0] variance,
	input  logic [2:0]       frame_blocks_log2,
	output logic [VAR_W-1:0] frame_noise,
	output logic             noise_valid
);

	logic [VAR_W+MAX_FRAME_LOG2-1:0] acc;
	logic [VAR_W+MAX_FRAME_LOG2-1:0] sum;
	logic [VAR_W+MAX_FRAME_LOG2-1:0] avg;
	logic                            frame_end;

	assign sum       = acc + {{MAX_FRAME_LOG2{1'b0}}, variance};
	assign avg       = sum >> frame_blocks_log2; // block count is a power of two
	assign frame_end = var_valid && last_block;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc         <= '0;
			noise_valid <= 1'b0;
		end else begin
			noise_valid <= frame_end;
			if (var_valid)
				acc <= last_block ? '0 : sum; // nothing carries into the next frame
		end
	end

	always_ff @(posedge clk) begin
		if (frame_end)
			frame_noise <= avg[VAR_W-1:0];
	end

	// last_block from the controller has to meet the final variance pulse
	a_last_with_var: assert property (@(posedge clk) disable iff (!rst_n)
		last_block |-> var_valid)
		else $error("last_block without a variance");

endmodule

/* src/wiener_stats_top.sv */
`timescale 1ns/1ps
// wiener block statistics top
// per-block floored mean and variance of a pixel stream, plus the
// frame noise estimate from the average block variance
module wiener_stats_top import wiener_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  pixel_in_t        pixel,
	input  logic [2:0]       frame_blocks_log2,
	output block_stat_t      stat,
	output logic             mean_valid,
	output logic             var_valid,
	output logic [VAR_W-1:0] frame_noise,
	output logic             noise_valid
);

	logic               shift_en;
	logic               replay_start;
	logic               last_block;
	logic [PIXEL_W-1:0] line_din;
	logic [PIXEL_W-1:0] line_dout;

	assign line_din = pixel.valid ? pixel.data : '0; // zeros enter during the flush

	block_stats_ctrl ctrl_inst (
		.clk               (clk),
		.rst_n             (rst_n),
		.pixel             (pixel),
		.mean_valid        (mean_valid),
		.frame_blocks_log2 (frame_blocks_log2),
		.shift_en          (shift_en),
		.replay_start      (replay_start),
		.last_block        (last_block)
	);

	mean_unit mean_unit_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.pixel      (pixel),
		.mean       (stat.mean),
		.mean_valid (mean_valid)
	);

	sample_delay_line delay_line_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.shift_en (shift_en),
		.din      (line_din),
		.dout     (line_dout)
	);

	variance_unit variance_unit_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.shift_en     (shift_en),
		.replay_start (replay_start),
		.sample       (line_dout),
		.mean         (stat.mean),
		.variance     (stat.variance),
		.var_valid    (var_valid)
	);

	noise_estimator noise_inst (
		.clk               (clk),
		.rst_n             (rst_n),
		.var_valid         (var_valid),
		.last_block        (last_block),
		.variance          (stat.variance),
		.frame_blocks_log2 (frame_blocks_log2),
		.frame_noise       (frame_noise),
		.noise_valid       (noise_valid)
	);

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps
// testbench clock and reset
// 8 ns clock, reset held low for the first 4 rising edges
module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		#1 rst_n = 1'b1; // released just after the edge
	end

endmodule

/* verif/wiener_stats_tb.sv */
`timescale 1ns/1ps
// testbench for the wiener block statistics top
// reads test frames from the tests file, drives them with optional idle gaps
// and checks block means, block variances and frame noise in stream order
module wiener_stats_tb import wiener_pkg::*; ();

	logic             clk;
	logic             rst_n;
	pixel_in_t        pixel;
	logic [2:0]       frame_blocks_log2;
	block_stat_t      stat;
	logic             mean_valid;
	logic             var_valid;
	logic [VAR_W-1:0] frame_noise;
	logic             noise_valid;

	// one entry per test
	string t_name[$];
	int    t_log2[$];
	int    t_gap[$];
	int    t_noise[$];
	int    t_base[$]; // index of the first pixel
	int    t_nblk[$];

	// one entry per pixel or per block, in stream order
	int pix[$];
	int blk_mean[$];
	int blk_var[$];
	int blk_test[$];
	int blk_num[$];

	int mean_idx;
	int var_idx;
	int noise_idx;
	int mean_errs;
	int var_errs;
	int noise_errs;
	int other_errs;
	int limit_cycles;

	tb_clock_gen clk_gen_inst (
		.clk   (clk),
		.rst_n (rst_n)
	);

	wiener_stats_top i_dut (
		.clk               (clk),
		.rst_n             (rst_n),
		.pixel             (pixel),
		.frame_blocks_log2 (frame_blocks_log2),
		.stat              (stat),
		.mean_valid        (mean_valid),
		.var_valid         (var_valid),
		.frame_noise       (frame_noise),
		.noise_valid       (noise_valid)
	);

	task automatic load_tests();
		int               fd;
		int               r;
		int               v;
		int               k;
		int               last;
		logic [8*24-1:0]  word;
		logic [8*24-1:0]  name;
		logic [8*128-1:0] line;
		int               l2;
		int               gap;
		int               noise;
		string            nm;
		fd = $fopen("verif/wiener_stats_tests.txt", "r");
		if (fd == 0) begin
			$display("Error: cannot open verif/wiener_stats_tests.txt");
			other_errs++;
			return;
		end
		while (!$feof(fd)) begin
			word = '0;
			r = $fscanf(fd, "%s", word);
			if (r != 1)
				break;
			if (word == "#") begin
				r = $fgets(line, fd); // rest of a comment line
			end else if (word == "test") begin
				name = '0;
				r = $fscanf(fd, "%s %d %d %d", name, l2, gap, noise);
				nm = string'(name);
				t_name.push_back(nm);
				t_log2.push_back(l2);
				t_gap.push_back(gap);
				t_noise.push_back(noise);
				t_base.push_back(pix.size());
				t_nblk.push_back(0);
			end else if (word == "blk" && t_name.size() > 0) begin
				for (k = 0; k < BLOCK_SAMPLES; k++) begin
					r = $fscanf(fd, "%d", v);
					pix.push_back(v);
				end
				r = $fscanf(fd, "%d", v);
				blk_mean.push_back(v);
				r = $fscanf(fd, "%d", v);
				blk_var.push_back(v);
				last = t_name.size() - 1;
				blk_test.push_back(last);
				blk_num.push_back(t_nblk[last]);
				t_nblk[last] = t_nblk[last] + 1;
			end else begin
				$display("Error: unknown entry in the tests file");
				other_errs++;
				break;
			end
		end
		$fclose(fd);
	endtask

	// drive one frame, then wait for its noise estimate
	task automatic run_test(input int t);
		int n;
		int i;
		int gap_len;
		int waited;
		n = t_nblk[t] * BLOCK_SAMPLES;
		frame_blocks_log2 = 3'(t_log2[t]);
		for (i = 0; i < n; i++) begin
			pixel.sof   = (i == 0);
			pixel.valid = 1'b1;
			pixel.data  = PIXEL_W'(pix[t_base[t] + i]);
			@(posedge clk);
			#1;
			pixel = '0;
			if (t_gap[t] != 0 && i < n - 1) begin
				gap_len = $urandom_range(3, 0);
				repeat (gap_len) begin
					@(posedge clk);
					#1;
				end
			end
		end
		waited = 0;
		while (noise_valid !== 1'b1 && waited < 64) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (noise_valid !== 1'b1) begin
			$display("Error: no noise_valid seen for test %s", t_name[t]);
			other_errs++;
		end
	endtask

	function automatic int total_errors();
		return mean_errs + var_errs + noise_errs + other_errs;
	endfunction

	task automatic report_counts();
		$display("Errors: mean %0d  variance %0d  noise %0d  other %0d",
			mean_errs, var_errs, noise_errs, other_errs);
	endtask

	always @(negedge clk) begin
		if (rst_n && mean_valid) begin
			if (mean_idx >= blk_mean.size()) begin
				$display("Error: mean_valid pulse with no block left to expect");
				other_errs++;
			end else begin
				if (stat.mean !== PIXEL_W'(blk_mean[mean_idx])) begin
					$display("Mismatch test %s block %0d mean: expected %0d actual %0d",
						t_name[blk_test[mean_idx]], blk_num[mean_idx],
						blk_mean[mean_idx], stat.mean);
					mean_errs++;
				end
				mean_idx++;
			end
		end
	end

	always @(negedge clk) begin
		if (rst_n && var_valid) begin
			if (var_idx >= blk_var.size()) begin
				$display("Error: var_valid pulse with no block left to expect");
				other_errs++;
			end else begin
				if (stat.variance !== VAR_W'(blk_var[var_idx])) begin
					$display("Mismatch test %s block %0d variance: expected %0d actual %0d",
						t_name[blk_test[var_idx]], blk_num[var_idx],
						blk_var[var_idx], stat.variance);
					var_errs++;
				end
				var_idx++;
			end
		end
	end

	always @(negedge clk) begin
		if (rst_n && noise_valid) begin
			if (noise_idx >= t_noise.size()) begin
				$display("Error: noise_valid pulse with no frame left to expect");
				other_errs++;
			end else begin
				if (frame_noise !== VAR_W'(t_noise[noise_idx])) begin
					$display("Mismatch test %s noise: expected %0d actual %0d",
						t_name[noise_idx], t_noise[noise_idx], frame_noise);
					noise_errs++;
				end
				noise_idx++;
			end
		end
	end

	initial begin
		pixel             = '0;
		frame_blocks_log2 = '0;
		void'($urandom(67)); // single seed for the run
		load_tests();
		limit_cycles = pix.size() * 5 + 200;
		foreach (t_name[t]) begin
			if (t_nblk[t] != (1 << t_log2[t])) begin
				$display("Error: test %s has %0d blocks but frame_blocks_log2 %0d",
					t_name[t], t_nblk[t], t_log2[t]);
				other_errs++;
			end
		end
		wait (rst_n === 1'b1);
		@(posedge clk);
		#1;
		foreach (t_name[t])
			run_test(t);
		repeat (4) @(posedge clk);
		#1;
		// pulses that never came
		if (mean_idx != blk_mean.size()) begin
			$display("Error: only %0d of %0d block means arrived", mean_idx, blk_mean.size());
			other_errs++;
		end
		if (var_idx != blk_var.size()) begin
			$display("Error: only %0d of %0d block variances arrived", var_idx, blk_var.size());
			other_errs++;
		end
		if (noise_idx != t_noise.size()) begin
			$display("Error: only %0d of %0d noise estimates arrived", noise_idx, t_noise.size());
			other_errs++;
		end
		report_counts();
		if (total_errors() == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// watchdog of about five cycles per pixel plus slack
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("Error: watchdog expired after %0d cycles", limit_cycles);
		other_errs++;
		report_counts();
		$display("Test failed");
		$finish;
	end

endmodule

/* verif/wiener_stats_tests.txt */
# test <name> <frame_blocks_log2> <gap flag> <expected frame noise>
# blk <8 pixels> <expected mean> <expected variance> and one blk line per block of the test
test const_frame 1 0 0
blk 90 90 90 90 90 90 90 90 90 0
blk 90 90 90 90 90 90 90 90 90 0
test ramp_single 0 0 525
blk 10 20 30 40 50 60 70 80 45 525
test two_blocks 1 0 2875
blk 3 7 1 9 4 4 8 2 4 8
blk 200 100 150 250 0 50 175 125 131 5742
test four_blocks 2 0 3206
blk 10 20 30 40 50 60 70 80 45 525
blk 200 100 150 250 0 50 175 125 131 5742
blk 255 255 255 255 255 255 255 254 254 0
blk 17 33 65 129 5 9 1 250 63 6558
test four_blocks_gap 2 1 3206
blk 10 20 30 40 50 60 70 80 45 525
blk 200 100 150 250 0 50 175 125 131 5742
blk 255 255 255 255 255 255 255 254 254 0
blk 17 33 65 129 5 9 1 250 63 6558
test back_to_back 1 0 2875
blk 200 100 150 250 0 50 175 125 131 5742
blk 3 7 1 9 4 4 8 2 4 8
test extreme_single 0 0 16256
blk 0 255 0 255 0 255 0 255 127 16256
test extreme_pair_gap 1 1 16256
blk 0 255 0 255 0 255 0 255 127 16256
blk 255 0 255 0 255 0 255 0 127 16256

/* all.f */
src/wiener_pkg.sv
src/block_stats_ctrl.sv
src/mean_unit.sv
src/sample_delay_line.sv
src/variance_unit.sv
src/noise_estimator.sv
src/wiener_stats_top.sv
verif/tb_clock_gen.sv
verif/wiener_stats_tb.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the wiener statistics testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module wiener_stats_tb \
	-Mdir obj_dir -o wiener_stats_sim \
	-f all.f

./obj_dir/wiener_stats_sim | tee sim.log

if grep -qx "Test passed" sim.log; then
	exit 0
fi
exit 1
